// File: build.f
+incdir+logic
logic/sha512_pkg.sv
logic/sha512_requestor.sv
logic/sha512_core.sv
logic/sha512_accel.sv
tb/sha512_checker.sv
tb/sha512_accel_tb.sv

// File: logic/sha512_accel.sv
// SHA-512 accelerator top
`timescale 1ns/1ps
`default_nettype none

module sha512_accel (
  input  logic                clk,
  input  logic                reset,
  input  logic                start,
  input  sha512_pkg::job_t    job,
  output sha512_pkg::rd_req_t rd_req,
  input  sha512_pkg::rd_rsp_t rd_rsp,
  input  logic                rd_alm_full,
  output sha512_pkg::wr_req_t wr_req,
  input  logic                wr_alm_full
);

  logic                   init;
  sha512_pkg::line_data_t block;
  logic                   block_valid;
  logic                   ready;
  sha512_pkg::digest_t    digest;
  logic                   digest_valid;

  sha512_requestor u_requestor (
    .clk(clk), .reset(reset), .start(start), .job(job),
    .rd_req(rd_req), .rd_rsp(rd_rsp), .rd_alm_full(rd_alm_full),
    .wr_req(wr_req), .wr_alm_full(wr_alm_full),
    .init(init), .block(block), .block_valid(block_valid), .ready(ready),
    .digest(digest), .digest_valid(digest_valid)
  );

  sha512_core u_core (
    .clk(clk), .reset(reset), .init(init),
    .block(block), .block_valid(block_valid), .ready(ready),
    .digest(digest), .digest_valid(digest_valid)
  );

endmodule : sha512_accel

`default_nettype wire

// File: logic/sha512_core.sv
// SHA-512 compression core
`timescale 1ns/1ps
`default_nettype none
`include "sha512_params.svh"

module sha512_core (
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   init,
  input  sha512_pkg::line_data_t block,
  input  logic                   block_valid,
  output logic                   ready,
  output sha512_pkg::digest_t    digest,
  output logic                   digest_valid
);

  localparam int cnt_w = $clog2(`SHA_ROUNDS + 1);

  sha512_pkg::core_state_t state;
  sha512_pkg::word64_t     hash [8];   // chained state
  sha512_pkg::word64_t     wv   [8];   // a to h
  sha512_pkg::word64_t     w    [16];  // schedule window, w[0] is current
  logic [cnt_w-1:0]        round_cnt;
  logic                    round_last;
  sha512_pkg::word64_t     t1;
  sha512_pkg::word64_t     t2;
  sha512_pkg::word64_t     w_next;

  function automatic sha512_pkg::word64_t rotr(input sha512_pkg::word64_t x, input int n);
    return (x >> n) | (x << (64 - n));
  endfunction

  // second half still in flight counts as busy
  assign ready = (state == sha512_pkg::core_idle) ||
                 (state == sha512_pkg::core_half && !block_valid);

  assign round_last = (round_cnt == cnt_w'(`SHA_ROUNDS));  // add cycle

  always_comb begin
    t1 = wv[7] + (rotr(wv[4], 14) ^ rotr(wv[4], 18) ^ rotr(wv[4], 41))
       + ((wv[4] & wv[5]) ^ (~wv[4] & wv[6]))
       + sha512_pkg::round_k(round_cnt) + w[0];
    t2 = (rotr(wv[0], 28) ^ rotr(wv[0], 34) ^ rotr(wv[0], 39))
       + ((wv[0] & wv[1]) ^ (wv[0] & wv[2]) ^ (wv[1] & wv[2]));
    w_next = (rotr(w[14], 19) ^ rotr(w[14], 61) ^ (w[14] >> 6)) + w[9]
           + (rotr(w[1], 1) ^ rotr(w[1], 8) ^ (w[1] >> 7)) + w[0];
  end

  always_comb begin
    for (int i = 0; i < 8; i++) begin
      digest[`SHA_LINE_W-1-64*i -: 64] = hash[i];
    end
  end

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      state        <= sha512_pkg::core_idle;
      round_cnt    <= '0;
      digest_valid <= 1'b0;
    end else begin
      digest_valid <= 1'b0;
      case (state)
        sha512_pkg::core_idle: begin
          if (block_valid) begin
            state <= sha512_pkg::core_half;
          end
        end
        sha512_pkg::core_half: begin
          if (block_valid) begin
            state     <= sha512_pkg::core_rounds;
            round_cnt <= '0;
          end
        end
        sha512_pkg::core_rounds: begin
          round_cnt <= round_cnt + 1'b1;
          if (round_last) begin
            state        <= sha512_pkg::core_idle;
            digest_valid <= 1'b1;
          end
        end
        default: state <= sha512_pkg::core_idle;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (init) begin
      for (int i = 0; i < 8; i++) begin
        hash[i] <= sha512_pkg::init_hash(3'(i));
      end
    end
    case (state)
      sha512_pkg::core_idle: begin
        if (block_valid) begin
          for (int i = 0; i < 8; i++) begin
            w[i] <= block[`SHA_LINE_W-1-64*i -: 64];  // words 0 to 7 are the high half
          end
        end
      end
      sha512_pkg::core_half: begin
        if (block_valid) begin
          for (int i = 0; i < 8; i++) begin
            w[8+i] <= block[`SHA_LINE_W-1-64*i -: 64];
            wv[i]  <= hash[i];
          end
        end
      end
      sha512_pkg::core_rounds: begin
        if (!round_last) begin
          for (int i = 0; i < 15; i++) begin
            w[i] <= w[i+1];
          end
          w[15] <= w_next;
          wv[0] <= t1 + t2;
          wv[1] <= wv[0];
          wv[2] <= wv[1];
          wv[3] <= wv[2];
          wv[4] <= wv[3] + t1;
          wv[5] <= wv[4];
          wv[6] <= wv[5];
          wv[7] <= wv[6];
        end else begin
          for (int i = 0; i < 8; i++) begin
            hash[i] <= hash[i] + wv[i];  // chain into next block
          end
        end
      end
      default: ;
    endcase
  end

  a_no_block_in_rounds: assert property (@(posedge clk) disable iff (reset)
    state == sha512_pkg::core_rounds |-> !block_valid);

endmodule : sha512_core

`default_nettype wire

// File: logic/sha512_params.svh
// SHA-512 accelerator parameters
`ifndef SHA512_PARAMS_SVH
`define SHA512_PARAMS_SVH

// width of a host line address
`define SHA_ADDR_W 32

// one host line or half a block
`define SHA_LINE_W 512

// compression rounds per block
`define SHA_ROUNDS 80

// reorder slots for two line pairs
`define SHA_SLOTS 4

`endif

// File: logic/sha512_pkg.sv
// SHA-512 shared types and tables
`default_nettype none
`include "sha512_params.svh"

package sha512_pkg;

  typedef logic [`SHA_ADDR_W-1:0] line_addr_t;
  typedef logic [`SHA_LINE_W-1:0] line_data_t;
  typedef logic [63:0]            word64_t;
  typedef logic [`SHA_LINE_W-1:0] digest_t;  // word 0 in the msbs

  typedef struct packed {
    line_addr_t src;
    line_addr_t len;     // even nonzero line count
    line_addr_t dst;
    line_addr_t status;
  } job_t;

  typedef struct packed {
    logic       valid;
    line_addr_t addr;
    logic       pair;    // two consecutive lines
  } rd_req_t;

  typedef struct packed {
    logic       valid;
    logic       cl_num;  // line within the pair
    line_data_t data;
  } rd_rsp_t;

  typedef struct packed {
    logic       valid;
    line_addr_t addr;
    line_data_t data;
  } wr_req_t;

  typedef enum logic [2:0] {rd_idle, rd_fetch, rd_wait_0, rd_wait_1, rd_finish} rd_state_t;
  typedef enum logic [1:0] {wr_idle, wr_data, wr_flag, wr_done} wr_state_t;
  typedef enum logic [1:0] {core_idle, core_half, core_rounds} core_state_t;

  localparam word64_t round_k_table [`SHA_ROUNDS] = '{
    64'h428a2f98d728ae22, 64'h7137449123ef65cd, 64'hb5c0fbcfec4d3b2f, 64'he9b5dba58189dbbc,
    64'h3956c25bf348b538, 64'h59f111f1b605d019, 64'h923f82a4af194f9b, 64'hab1c5ed5da6d8118,
    64'hd807aa98a3030242, 64'h12835b0145706fbe, 64'h243185be4ee4b28c, 64'h550c7dc3d5ffb4e2,
    64'h72be5d74f27b896f, 64'h80deb1fe3b1696b1, 64'h9bdc06a725c71235, 64'hc19bf174cf692694,
    64'he49b69c19ef14ad2, 64'hefbe4786384f25e3, 64'h0fc19dc68b8cd5b5, 64'h240ca1cc77ac9c65,
    64'h2de92c6f592b0275, 64'h4a7484aa6ea6e483, 64'h5cb0a9dcbd41fbd4, 64'h76f988da831153b5,
    64'h983e5152ee66dfab, 64'ha831c66d2db43210, 64'hb00327c898fb213f, 64'hbf597fc7beef0ee4,
    64'hc6e00bf33da88fc2, 64'hd5a79147930aa725, 64'h06ca6351e003826f, 64'h142929670a0e6e70,
    64'h27b70a8546d22ffc, 64'h2e1b21385c26c926, 64'h4d2c6dfc5ac42aed, 64'h53380d139d95b3df,
    64'h650a73548baf63de, 64'h766a0abb3c77b2a8, 64'h81c2c92e47edaee6, 64'h92722c851482353b,
    64'ha2bfe8a14cf10364, 64'ha81a664bbc423001, 64'hc24b8b70d0f89791, 64'hc76c51a30654be30,
    64'hd192e819d6ef5218, 64'hd69906245565a910, 64'hf40e35855771202a, 64'h106aa07032bbd1b8,
    64'h19a4c116b8d2d0c8, 64'h1e376c085141ab53, 64'h2748774cdf8eeb99, 64'h34b0bcb5e19b48a8,
    64'h391c0cb3c5c95a63, 64'h4ed8aa4ae3418acb, 64'h5b9cca4f7763e373, 64'h682e6ff3d6b2b8a3,
    64'h748f82ee5defb2fc, 64'h78a5636f43172f60, 64'h84c87814a1f0ab72, 64'h8cc702081a6439ec,
    64'h90befffa23631e28, 64'ha4506cebde82bde9, 64'hbef9a3f7b2c67915, 64'hc67178f2e372532b,
    64'hca273eceea26619c, 64'hd186b8c721c0c207, 64'heada7dd6cde0eb1e, 64'hf57d4f7fee6ed178,
    64'h06f067aa72176fba, 64'h0a637dc5a2c898a6, 64'h113f9804bef90dae, 64'h1b710b35131c471b,
    64'h28db77f523047d84, 64'h32caab7b40c72493, 64'h3c9ebe0a15c9bebc, 64'h431d67c49c100d4c,
    64'h4cc5d4becb3e42b6, 64'h597f299cfc657e2a, 64'h5fcb6fab3ad6faec, 64'h6c44198c4a475817
  };

  localparam word64_t init_hash_table [8] = '{
    64'h6a09e667f3bcc908, 64'hbb67ae8584caa73b, 64'h3c6ef372fe94f82b, 64'ha54ff53a5f1d36f1,
    64'h510e527fade682d1, 64'h9b05688c2b3e6c1f, 64'h1f83d9abfb41bd6b, 64'h5be0cd19137e2179
  };

  function automatic word64_t round_k(input logic [6:0] idx);
    return round_k_table[idx];
  endfunction

  function automatic word64_t init_hash(input logic [2:0] idx);
    return init_hash_table[idx];
  endfunction

endpackage : sha512_pkg

`default_nettype wire

// File: logic/sha512_requestor.sv
// SHA-512 host requestor
`timescale 1ns/1ps
`default_nettype none
`include "sha512_params.svh"

module sha512_requestor (
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   start,
  input  sha512_pkg::job_t       job,
  output sha512_pkg::rd_req_t    rd_req,
  input  sha512_pkg::rd_rsp_t    rd_rsp,
  input  logic                   rd_alm_full,
  output sha512_pkg::wr_req_t    wr_req,
  input  logic                   wr_alm_full,
  output logic                   init,
  output sha512_pkg::line_data_t block,
  output logic                   block_valid,
  input  logic                   ready,
  input  sha512_pkg::digest_t    digest,
  input  logic                   digest_valid
);

  localparam int slot_w = $clog2(`SHA_SLOTS);

  sha512_pkg::job_t       job_q;
  sha512_pkg::rd_state_t  rd_state;
  sha512_pkg::wr_state_t  wr_state;
  sha512_pkg::line_addr_t rd_offset;
  sha512_pkg::line_addr_t digest_cnt;
  sha512_pkg::line_data_t slot_data [`SHA_SLOTS];
  logic [`SHA_SLOTS-1:0]  slot_dirty;
  logic [1:0]             rsp_cnt;      // bit 1 of the line count picks the pair
  logic [slot_w-1:0]      rsp_slot;
  logic [slot_w-1:0]      ptr;          // next slot to the core
  logic                   pair_free;
  logic                   job_start;
  logic                   fwd;

  assign job_start = start && (rd_state == sha512_pkg::rd_idle);
  assign rsp_slot  = {rsp_cnt[1], rd_rsp.cl_num};
  assign fwd       = ready && slot_dirty[ptr];

  // both slots of the next pair must be drained before asking for it
  assign pair_free = !slot_dirty[{rd_offset[1], 1'b0}] && !slot_dirty[{rd_offset[1], 1'b1}];

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      init <= 1'b0;
    end else begin
      init <= job_start;  // core reloads its iv
    end
  end

  always_ff @(posedge clk) begin
    if (job_start) begin
      job_q <= job;
    end
  end

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      rd_state  <= sha512_pkg::rd_idle;
      rd_req    <= '0;
      rd_offset <= '0;
    end else begin
      rd_req.valid <= 1'b0;
      case (rd_state)
        sha512_pkg::rd_idle: begin
          rd_offset <= '0;
          if (job_start) begin
            rd_state <= sha512_pkg::rd_fetch;
          end
        end
        sha512_pkg::rd_fetch: begin
          if (!rd_alm_full && pair_free) begin
            rd_req.valid <= 1'b1;
            rd_req.addr  <= job_q.src + rd_offset;
            rd_req.pair  <= 1'b1;
            rd_offset    <= rd_offset + 32'd2;
            if (rd_offset + 32'd2 == job_q.len) begin
              rd_state <= sha512_pkg::rd_finish;
            end else begin
              rd_state <= sha512_pkg::rd_wait_0;
            end
          end
        end
        sha512_pkg::rd_wait_0: begin
          if (rd_rsp.valid) begin
            rd_state <= sha512_pkg::rd_wait_1;
          end
        end
        sha512_pkg::rd_wait_1: begin
          if (rd_rsp.valid) begin
            rd_state <= sha512_pkg::rd_fetch;
          end
        end
        sha512_pkg::rd_finish: begin
          if (wr_state == sha512_pkg::wr_done) begin
            rd_state <= sha512_pkg::rd_idle;  // job over
          end
        end
        default: rd_state <= sha512_pkg::rd_idle;
      endcase
    end
  end

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      slot_dirty <= '0;
      rsp_cnt    <= '0;
    end else begin
      if (job_start) begin
        rsp_cnt <= '0;
      end else if (rd_rsp.valid) begin
        rsp_cnt <= rsp_cnt + 2'd1;
      end
      if (rd_rsp.valid) begin
        slot_dirty[rsp_slot] <= 1'b1;
      end
      if (fwd) begin
        slot_dirty[ptr] <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rd_rsp.valid) begin
      slot_data[rsp_slot] <= rd_rsp.data;
    end
    if (fwd) begin
      block <= slot_data[ptr];
    end
  end

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      ptr         <= '0;
      block_valid <= 1'b0;
      digest_cnt  <= '0;
    end else begin
      block_valid <= fwd;
      if (job_start) begin
        ptr        <= '0;
        digest_cnt <= '0;
      end else begin
        if (fwd) begin
          ptr <= ptr + 1'b1;
        end
        if (digest_valid) begin
          digest_cnt <= digest_cnt + 32'd1;  // one per block
        end
      end
    end
  end

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      wr_state <= sha512_pkg::wr_idle;
      wr_req   <= '0;
    end else begin
      wr_req.valid <= 1'b0;
      case (wr_state)
        sha512_pkg::wr_idle: begin
          if (rd_state == sha512_pkg::rd_finish && digest_cnt == (job_q.len >> 1)) begin
            wr_state <= sha512_pkg::wr_data;
          end
        end
        sha512_pkg::wr_data: begin
          if (!wr_alm_full) begin
            wr_req.valid <= 1'b1;
            wr_req.addr  <= job_q.dst;
            wr_req.data  <= digest;
            wr_state     <= sha512_pkg::wr_flag;
          end
        end
        sha512_pkg::wr_flag: begin
          if (!wr_alm_full) begin
            wr_req.valid <= 1'b1;
            wr_req.addr  <= job_q.status;
            wr_req.data  <= sha512_pkg::line_data_t'(1);  // done flag
            wr_state     <= sha512_pkg::wr_done;
          end
        end
        default: wr_state <= sha512_pkg::wr_idle;
      endcase
    end
  end

  a_rd_throttle: assert property (@(posedge clk) disable iff (reset)
    rd_req.valid |-> !$past(rd_alm_full));
  a_wr_throttle: assert property (@(posedge clk) disable iff (reset)
    wr_req.valid |-> !$past(wr_alm_full));
  a_block_ready: assert property (@(posedge clk) disable iff (reset)
    block_valid |-> $past(ready));
  a_start_idle: assert property (@(posedge clk) disable iff (reset)
    start |-> rd_state == sha512_pkg::rd_idle);

endmodule : sha512_requestor

`default_nettype wire

// File: run.sh
#!/usr/bin/env bash
# Build and run the SHA-512 accelerator simulation with Verilator.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  -f build.f --top-module sha512_accel_tb -Mdir obj_dir
if [ $? -ne 0 ]; then
  echo "Verilator compile failed"
  exit 1
fi

sim_out=$(./obj_dir/Vsha512_accel_tb)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
  echo "simulation exited with status $sim_status"
  exit 1
fi

if echo "$sim_out" | grep -qx "Simulation finished: PASS"; then
  exit 0
fi
echo "pass message not found"
exit 1

// File: tb/sha512_accel_tb.sv
// SHA-512 accelerator testbench
`timescale 1ns/1ps
`default_nettype none
`include "sha512_params.svh"

module sha512_accel_tb;

  localparam int mem_lines    = 64;
  localparam int num_jobs     = 3;
  localparam int max_len      = 12;
  localparam int limit_cycles = num_jobs * (max_len * 200 + 500);

  logic                   clk = 1'b0;
  logic                   reset;
  logic                   start;
  sha512_pkg::job_t       job;
  sha512_pkg::rd_req_t    rd_req;
  sha512_pkg::rd_rsp_t    rd_rsp = '0;
  logic                   rd_alm_full = 1'b0;
  sha512_pkg::wr_req_t    wr_req;
  logic                   wr_alm_full = 1'b0;
  sha512_pkg::line_data_t mem [mem_lines];
  integer                 seed = 32'ha7fe5cc4;
  int                     cycle = 0;
  int                     errors;
  int                     jobs_checked;

  sha512_pkg::line_addr_t pend_addr [$];  // pairs waiting for their delay
  int                     pend_due [$];
  logic                   pend_swap [$];
  logic                   second_pending = 1'b0;
  sha512_pkg::line_addr_t second_addr;
  logic                   second_cl;
  logic                   wr_v;
  sha512_pkg::line_addr_t wr_a;
  sha512_pkg::line_data_t wr_d;

  always #4 clk = ~clk;

  sha512_accel u_sha512_accel (
    .clk(clk), .reset(reset), .start(start), .job(job),
    .rd_req(rd_req), .rd_rsp(rd_rsp), .rd_alm_full(rd_alm_full),
    .wr_req(wr_req), .wr_alm_full(wr_alm_full)
  );

  sha512_checker #(.mem_lines(mem_lines)) u_checker (
    .clk(clk), .reset(reset), .start(start), .job(job),
    .rd_req(rd_req), .rd_alm_full(rd_alm_full),
    .wr_req(wr_req), .wr_alm_full(wr_alm_full),
    .mem(mem), .errors(errors), .jobs_checked(jobs_checked)
  );

  // host memory answering each pair after 2 to 9 cycles
  always @(posedge clk) begin
    if (rd_req.valid) begin
      pend_addr.push_back(rd_req.addr);
      pend_due.push_back(cycle + 2 + ($random(seed) & 7));
      pend_swap.push_back(1'($random(seed)));
    end
    wr_v = wr_req.valid;
    wr_a = wr_req.addr;
    wr_d = wr_req.data;
    #1;
    cycle++;
    if (wr_v) begin
      mem[wr_a] = wr_d;
    end
    rd_alm_full = ($random(seed) & 3) == 0;  // about a quarter of the time
    wr_alm_full = ($random(seed) & 3) == 0;
    rd_rsp = '0;
    if (second_pending) begin
      rd_rsp.valid   = 1'b1;
      rd_rsp.cl_num  = second_cl;
      rd_rsp.data    = mem[second_addr + 32'(second_cl)];
      second_pending = 1'b0;
    end else if (pend_addr.size() > 0 && pend_due[0] <= cycle) begin
      rd_rsp.valid   = 1'b1;
      rd_rsp.cl_num  = pend_swap[0];  // either line may come first
      rd_rsp.data    = mem[pend_addr[0] + 32'(pend_swap[0])];
      second_pending = 1'b1;
      second_addr    = pend_addr[0];
      second_cl      = ~pend_swap[0];
      void'(pend_addr.pop_front());
      void'(pend_due.pop_front());
      void'(pend_swap.pop_front());
    end
  end

  task automatic fill_memory();
    for (int a = 0; a < mem_lines; a++) begin
      for (int k = 0; k < 16; k++) begin
        mem[a][32*k +: 32] = $random(seed);
      end
    end
  endtask

  task automatic wait_status(input sha512_pkg::line_addr_t status);
    do begin
      @(posedge clk);
    end while (!(wr_req.valid && wr_req.addr == status));
  endtask

  task automatic run_job(input sha512_pkg::line_addr_t src, input sha512_pkg::line_addr_t len,
                         input sha512_pkg::line_addr_t dst, input sha512_pkg::line_addr_t status);
    @(posedge clk);
    #1;
    job.src    = src;
    job.len    = len;
    job.dst    = dst;
    job.status = status;
    start      = 1'b1;
    @(posedge clk);
    #1;
    start = 1'b0;
    wait_status(status);
  endtask

  initial begin
    reset = 1'b1;
    start = 1'b0;
    job   = '0;
    fill_memory();
    repeat (5) @(posedge clk);
    #1;
    reset = 1'b0;
    repeat (3) @(posedge clk);
    run_job(32'd0, 32'd2, 32'd48, 32'd49);    // single block
    run_job(32'd2, 32'd12, 32'd50, 32'd51);   // six chained blocks
    run_job(32'd14, 32'd4, 32'd52, 32'd53);   // new message restarts the chaining
    repeat (4) @(posedge clk);
    $display("checker: %0d errors, %0d of %0d jobs checked", errors, jobs_checked, num_jobs);
    if (errors == 0 && jobs_checked == num_jobs) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

  initial begin
    repeat (limit_cycles) @(posedge clk);
    $display("watchdog: jobs did not complete within %0d cycles, the accelerator hung",
             limit_cycles);
    $display("checker: %0d errors, %0d of %0d jobs checked", errors, jobs_checked, num_jobs);
    $display("Simulation finished: FAIL");
    $finish;
  end

endmodule : sha512_accel_tb

`default_nettype wire

// File: tb/sha512_checker.sv
// SHA-512 accelerator checker
`timescale 1ns/1ps
`default_nettype none
`include "sha512_params.svh"

module sha512_checker #(
  parameter int mem_lines = 64
) (
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   start,
  input  sha512_pkg::job_t       job,
  input  sha512_pkg::rd_req_t    rd_req,
  input  logic                   rd_alm_full,
  input  sha512_pkg::wr_req_t    wr_req,
  input  logic                   wr_alm_full,
  input  sha512_pkg::line_data_t mem [mem_lines],
  output int                     errors,
  output int                     jobs_checked
);

  sha512_pkg::job_t    cur_job;
  sha512_pkg::digest_t exp_digest;
  logic                active;
  logic                rd_af_q;  // flag as seen at the previous edge
  logic                wr_af_q;
  int                  rd_cnt;
  int                  wr_cnt;

  function automatic sha512_pkg::word64_t rotate_right(input sha512_pkg::word64_t x,
                                                       input int n);
    logic [127:0] both;
    both = {x, x} >> n;
    return both[63:0];
  endfunction

  // one 1024-bit block into the chained state
  function automatic sha512_pkg::digest_t compress_block(input sha512_pkg::digest_t h_in,
                                                         input logic [1023:0] blk);
    sha512_pkg::word64_t w [80];
    sha512_pkg::word64_t v [8];
    sha512_pkg::word64_t s0;
    sha512_pkg::word64_t s1;
    sha512_pkg::word64_t t1;
    sha512_pkg::word64_t t2;
    sha512_pkg::digest_t h_out;
    for (int t = 0; t < 16; t++) begin
      w[t] = blk[1023-64*t -: 64];
    end
    for (int t = 16; t < `SHA_ROUNDS; t++) begin
      s0 = rotate_right(w[t-15], 1) ^ rotate_right(w[t-15], 8) ^ (w[t-15] >> 7);
      s1 = rotate_right(w[t-2], 19) ^ rotate_right(w[t-2], 61) ^ (w[t-2] >> 6);
      w[t] = s1 + w[t-7] + s0 + w[t-16];
    end
    for (int i = 0; i < 8; i++) begin
      v[i] = h_in[511-64*i -: 64];
    end
    for (int t = 0; t < `SHA_ROUNDS; t++) begin
      s1 = rotate_right(v[4], 14) ^ rotate_right(v[4], 18) ^ rotate_right(v[4], 41);
      t1 = v[7] + s1 + ((v[4] & v[5]) ^ (~v[4] & v[6])) + sha512_pkg::round_k(7'(t)) + w[t];
      s0 = rotate_right(v[0], 28) ^ rotate_right(v[0], 34) ^ rotate_right(v[0], 39);
      t2 = s0 + ((v[0] & v[1]) ^ (v[0] & v[2]) ^ (v[1] & v[2]));
      for (int i = 7; i > 0; i--) begin
        v[i] = v[i-1];
      end
      v[4] = v[4] + t1;  // old d plus t1
      v[0] = t1 + t2;
    end
    for (int i = 0; i < 8; i++) begin
      h_out[511-64*i -: 64] = h_in[511-64*i -: 64] + v[i];
    end
    return h_out;
  endfunction

  function automatic sha512_pkg::digest_t message_digest(input sha512_pkg::line_addr_t src,
                                                         input sha512_pkg::line_addr_t len);
    sha512_pkg::digest_t h;
    for (int i = 0; i < 8; i++) begin
      h[511-64*i -: 64] = sha512_pkg::init_hash(3'(i));
    end
    for (int b = 0; b < int'(len) / 2; b++) begin
      h = compress_block(h, {mem[int'(src) + 2*b], mem[int'(src) + 2*b + 1]});
    end
    return h;
  endfunction

  task automatic check_read();
    sha512_pkg::line_addr_t exp_addr;
    exp_addr = cur_job.src + sha512_pkg::line_addr_t'(2 * rd_cnt);
    if (rd_af_q) begin
      errors++;
      $display("%0t: read request issued while rd_alm_full was high", $time);
    end
    if (!active) begin
      errors++;
      $display("%0t: read request with no job running", $time);
    end else begin
      if (rd_req.addr != exp_addr) begin
        errors++;
        $display("[ERROR] %0t rd_req.addr expected %h actual %h", $time, exp_addr, rd_req.addr);
      end
      if (!rd_req.pair) begin
        errors++;
        $display("[ERROR] %0t rd_req.pair expected 1 actual 0", $time);
      end
      if (rd_req.addr < cur_job.src || rd_req.addr + 32'd2 > cur_job.src + cur_job.len) begin
        errors++;
        $display("%0t: read request outside the source buffer", $time);
      end
      rd_cnt++;
    end
  endtask

  task automatic check_write();
    if (wr_af_q) begin
      errors++;
      $display("%0t: write request issued while wr_alm_full was high", $time);
    end
    if (!active) begin
      errors++;
      $display("%0t: write request with no job running", $time);
    end else if (wr_cnt == 0) begin
      if (wr_req.addr != cur_job.dst) begin
        errors++;
        $display("[ERROR] %0t wr_req.addr expected %h actual %h", $time, cur_job.dst, wr_req.addr);
      end
      if (wr_req.data != exp_digest) begin
        errors++;
        $display("[ERROR] %0t wr_req.data expected %h actual %h", $time, exp_digest, wr_req.data);
      end
      wr_cnt = 1;
    end else begin
      if (wr_req.addr != cur_job.status) begin
        errors++;
        $display("[ERROR] %0t wr_req.addr expected %h actual %h", $time, cur_job.status,
                 wr_req.addr);
      end
      if (wr_req.data != sha512_pkg::line_data_t'(1)) begin
        errors++;
        $display("[ERROR] %0t wr_req.data expected 1 actual %h", $time, wr_req.data);
      end
      if (rd_cnt != int'(cur_job.len) / 2) begin
        errors++;
        $display("[ERROR] %0t rd_req count expected %0d actual %0d", $time,
                 int'(cur_job.len) / 2, rd_cnt);
      end
      jobs_checked++;
      active = 1'b0;  // status write ends the job
    end
  endtask

  always @(posedge clk) begin
    if (reset) begin
      errors       = 0;
      jobs_checked = 0;
      active       = 1'b0;
      rd_cnt       = 0;
      wr_cnt       = 0;
    end else begin
      if (start) begin
        if (active) begin
          errors++;
          $display("%0t: start strobed while a job was running", $time);
        end
        cur_job    = job;
        exp_digest = message_digest(job.src, job.len);
        active     = 1'b1;
        rd_cnt     = 0;
        wr_cnt     = 0;
      end
      if (rd_req.valid) begin
        check_read();
      end
      if (wr_req.valid) begin
        check_write();
      end
    end
    rd_af_q = rd_alm_full;
    wr_af_q = wr_alm_full;
  end

endmodule : sha512_checker

`default_nettype wire
